// ==== Makefile ====
# Verilator build and run of the reorder buffer retirement testbench
TOP := tb_rob_top

SRCS := rob_defines.svh rob_pkg.sv rob_ctrl.sv rob_entry_array.sv \
	rob_commit_count.sv rob_top.sv tb_rob_top.sv

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): rob_top.f $(SRCS)
	verilator --binary --timing --assert -f rob_top.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f rob_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== rob_commit_count.sv ====
// ====================================================================
// Retire group decision for the reorder buffer
// Looks at the entries from the head, wrapping around the buffer,
// and returns how many may retire this cycle and whether the group
// ends with an excepting entry
// ====================================================================

`include "rob_defines.svh"

module rob_commit_count (
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] entries,
	input  rob_pkg::rob_ndx_t                      head,
	output rob_pkg::cmt_cnt_t                      cmt_cnt,
	output logic                                   cmt_flush
);
	import rob_pkg::*;

	// Window of candidate entries, lane 0 is the head
	rob_entry_t [`CMT_WIDTH-1:0] win;

	// Lane may retire on its own merits
	logic [`CMT_WIDTH-1:0] ready;

	// Lane belongs to the leading run from the head
	logic [`CMT_WIDTH-1:0] run;

	// ================================================================
	// Candidate window
	// ================================================================

	// Index arithmetic wraps modulo the depth because the depth is a
	// power of two and the sum keeps the index width
	always_comb begin
		for (int k = 0; k < `CMT_WIDTH; k++)
			win[k] = entries[head + rob_ndx_t'(k)];
	end

	// Only allocated and finished entries qualify
	// All lanes of one group share the head's checkpoint index, since the
	// rename side takes one checkpoint update per cycle
	always_comb begin
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			ready[k] = win[k].valid && win[k].done &&
				(win[k].cndx == win[0].cndx);
		end
	end

	// ================================================================
	// Group formation
	// ================================================================

	// An oddball or an excepting entry closes the group behind itself
	// Earlier lanes are already covered by the run bit of the lane before
	always_comb begin
		run[0] = ready[0];
		for (int k = 1; k < `CMT_WIDTH; k++) begin
			run[k] = run[k-1] && ready[k] &&
				!win[k-1].oddball && !win[k-1].excv;
		end
	end

	// The run is a prefix of ones, so its last set lane gives the count
	// The flush comes from the excepting entry at the end of the group,
	// which is the only place an exception can sit in a run
	always_comb begin
		cmt_cnt   = '0;
		cmt_flush = 1'b0;
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			if (run[k]) begin
				cmt_cnt   = cmt_cnt_t'(k + 1);
				cmt_flush = win[k].excv;
			end
		end
	end

endmodule

// ==== rob_ctrl.sv ====
// ====================================================================
// Reorder buffer pointer control
// Head, tail and occupancy registers, the full flag, the gated
// dispatch and retire strobes, and the flush on an exception
// ====================================================================

`include "rob_defines.svh"

module rob_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              disp_valid,
	input  rob_pkg::cmt_cnt_t cmt_cnt,
	input  logic              cmt_flush,
	output rob_pkg::rob_ndx_t head,
	output rob_pkg::rob_ndx_t tail,
	output logic              disp_we,
	output logic              full,
	output logic              ret_we,
	output logic              flush_now,
	output logic              flush
);
	import rob_pkg::*;

	// One bit wider than the index so a full buffer can be told apart
	// from an empty one
	typedef logic [`ROB_NDX_W:0] occ_t;

	occ_t     occ;
	occ_t     occ_nxt;
	rob_ndx_t head_nxt;
	rob_ndx_t tail_nxt;

	// ================================================================
	// Strobes
	// ================================================================

	// A flush only comes with a retiring group, the excepting entry is
	// always its last member
	// Dispatch in the flush cycle is dropped since the younger entries
	// are being thrown away
	always_comb begin
		full      = (occ == occ_t'(`ROB_ENTRIES));
		ret_we    = (cmt_cnt != '0);
		flush_now = cmt_flush && ret_we;
		disp_we   = disp_valid && !full && !flush_now;
	end

	// ================================================================
	// Pointer and occupancy update
	// ================================================================

	// Head always moves past the retired group
	// On a flush the tail snaps back onto the new head and the buffer
	// is empty again
	always_comb begin
		head_nxt = head + rob_ndx_t'(cmt_cnt);
		if (flush_now) begin
			tail_nxt = head_nxt;
			occ_nxt  = '0;
		end else begin
			tail_nxt = tail + rob_ndx_t'(disp_we);
			occ_nxt  = occ + occ_t'(disp_we) - occ_t'(cmt_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			occ   <= '0;
			flush <= 1'b0;
		end else begin
			head  <= head_nxt;
			tail  <= tail_nxt;
			occ   <= occ_nxt;
			flush <= flush_now;
		end
	end

	// The front end watches full and holds dispatch while it is set
	a_no_disp_full: assert property (@(posedge clk) disable iff (rst)
		!(disp_valid && full));

	// The commit counter only sees valid entries, so its count can never
	// run past what the pointers hold
	a_cmt_le_occ: assert property (@(posedge clk) disable iff (rst)
		occ_t'(cmt_cnt) <= occ);

endmodule

// ==== rob_defines.svh ====
// ====================================================================
// Sizing macros for the reorder buffer retirement block
// Buffer depth and index width, retire group width, and the widths
// of the checkpoint index, the tag and the result word
// ====================================================================

`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// The depth is a power of two, so index arithmetic wraps by itself
`define ROB_ENTRIES 16
`define ROB_NDX_W   4

// Largest group of entries that may leave the buffer in one clock
`define CMT_WIDTH   4

// Payload widths carried by each entry
`define CNDX_W      2
`define TAG_W       16
`define DATA_W      32

`endif

// ==== rob_entry_array.sv ====
// ====================================================================
// Reorder buffer entry storage
// Dispatch writes at the tail, completion marks entries done in any
// order, and retire or flush clears valid bits
// The retiring group is gathered from the head onto a registered bus
// ====================================================================

`include "rob_defines.svh"

module rob_entry_array (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    disp_we,
	input  rob_pkg::rob_ndx_t                       tail,
	input  rob_pkg::disp_t                          disp,
	input  logic                                    cpl_valid,
	input  rob_pkg::cpl_t                           cpl,
	input  rob_pkg::rob_ndx_t                       head,
	input  logic                                    ret_we,
	input  rob_pkg::cmt_cnt_t                       cmt_cnt,
	input  logic                                    flush_now,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]  entries,
	output logic                                    ret_valid,
	output rob_pkg::cmt_cnt_t                       ret_cnt,
	output rob_pkg::ret_slot_t  [`CMT_WIDTH-1:0]    ret_slots
);
	import rob_pkg::*;

	// Valid and done bits are the control state of each entry
	logic [`ROB_ENTRIES-1:0] vld;
	logic [`ROB_ENTRIES-1:0] dne;

	// Payload, only meaningful while the matching valid bit is set
	logic    [`ROB_ENTRIES-1:0] excv;
	disp_t   [`ROB_ENTRIES-1:0] dsp;
	result_u [`ROB_ENTRIES-1:0] res;

	ret_slot_t [`CMT_WIDTH-1:0] slots_nxt;

	// ================================================================
	// Entry state
	// ================================================================

	// A flush drops every entry, otherwise only the retiring ones go
	// Dispatch never lands on a retiring slot since a full buffer
	// refuses dispatch and an empty one has nothing to retire
	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
			dne <= '0;
		end else begin
			if (flush_now) begin
				vld <= '0;
			end else if (ret_we) begin
				for (int k = 0; k < `CMT_WIDTH; k++) begin
					if (cmt_cnt_t'(k) < cmt_cnt)
						vld[head + rob_ndx_t'(k)] <= 1'b0;
				end
			end
			if (disp_we) begin
				vld[tail] <= 1'b1;
				dne[tail] <= 1'b0;
			end
			if (cpl_valid)
				dne[cpl.ndx] <= 1'b1;
		end
	end

	// Payload written by dispatch and by the completion strobe
	always_ff @(posedge clk) begin
		if (disp_we) begin
			dsp[tail]  <= disp;
			excv[tail] <= 1'b0;
		end
		if (cpl_valid) begin
			excv[cpl.ndx] <= cpl.excv;
			res[cpl.ndx]  <= cpl.result;
		end
	end

	// Present the storage as whole entries to the commit counter
	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			entries[i].valid   = vld[i];
			entries[i].done    = dne[i];
			entries[i].excv    = excv[i];
			entries[i].oddball = dsp[i].oddball;
			entries[i].cndx    = dsp[i].cndx;
			entries[i].tag     = dsp[i].tag;
			entries[i].result  = res[i];
		end
	end

	// ================================================================
	// Retire bus
	// ================================================================

	// Slot 0 carries the head entry, lanes past the count stay zero
	always_comb begin
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			slots_nxt[k] = '0;
			if (ret_we && cmt_cnt_t'(k) < cmt_cnt) begin
				slots_nxt[k].tag     = entries[head + rob_ndx_t'(k)].tag;
				slots_nxt[k].cndx    = entries[head + rob_ndx_t'(k)].cndx;
				slots_nxt[k].oddball = entries[head + rob_ndx_t'(k)].oddball;
				slots_nxt[k].excv    = entries[head + rob_ndx_t'(k)].excv;
				slots_nxt[k].result  = entries[head + rob_ndx_t'(k)].result;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ret_valid <= 1'b0;
			ret_cnt   <= '0;
		end else begin
			ret_valid <= ret_we;
			ret_cnt   <= cmt_cnt;
		end
	end

	always_ff @(posedge clk)
		ret_slots <= slots_nxt;

	// Completion must hit an entry dispatched earlier and not yet done
	a_cpl_target: assert property (@(posedge clk) disable iff (rst)
		cpl_valid |-> (vld[cpl.ndx] && !dne[cpl.ndx]));

endmodule

// ==== rob_pkg.sv ====
// ====================================================================
// Shared types for the reorder buffer retirement block
// Index and count types, the exception record and result union,
// and the dispatch, completion, entry and retire slot records
// ====================================================================

`include "rob_defines.svh"

package rob_pkg;

	// Buffer index and retire count, the count runs from 0 to CMT_WIDTH
	typedef logic [`ROB_NDX_W-1:0] rob_ndx_t;
	typedef logic [$clog2(`CMT_WIDTH+1)-1:0] cmt_cnt_t;

	// Exception record, the cause sits in the top byte of the word
	typedef struct packed {
		logic [7:0]         cause;
		logic [`DATA_W-9:0] fault;
	} exc_rec_t;

	// A completion word is plain data, or an exception record when the
	// exception flag that travels beside it is set
	typedef union packed {
		logic [`DATA_W-1:0] data;
		exc_rec_t           exc;
	} result_u;

	// What the front end hands over when an instruction is dispatched
	typedef struct packed {
		logic [`TAG_W-1:0]  tag;
		logic [`CNDX_W-1:0] cndx;
		logic               oddball;
	} disp_t;

	// Completion strobe payload, the index selects the entry to mark
	typedef struct packed {
		rob_ndx_t ndx;
		logic     excv;
		result_u  result;
	} cpl_t;

	// One stored entry of the buffer
	typedef struct packed {
		logic               valid;
		logic               done;
		logic               excv;
		logic               oddball;
		logic [`CNDX_W-1:0] cndx;
		logic [`TAG_W-1:0]  tag;
		result_u            result;
	} rob_entry_t;

	// One lane of the retire bus
	typedef struct packed {
		logic [`TAG_W-1:0]  tag;
		logic [`CNDX_W-1:0] cndx;
		logic               oddball;
		logic               excv;
		result_u            result;
	} ret_slot_t;

endpackage

// ==== rob_top.f ====
+incdir+.
rob_pkg.sv
rob_ctrl.sv
rob_entry_array.sv
rob_commit_count.sv
rob_top.sv
tb_rob_top.sv

// ==== rob_top.sv ====
// ====================================================================
// Reorder buffer retirement top level
// Connects the pointer control, the entry storage and the
// combinational commit counter
// ====================================================================

`include "rob_defines.svh"

module rob_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  disp_valid,
	input  rob_pkg::disp_t                        disp,
	output rob_pkg::rob_ndx_t                     disp_ndx,
	output logic                                  full,
	input  logic                                  cpl_valid,
	input  rob_pkg::cpl_t                         cpl,
	output logic                                  ret_valid,
	output rob_pkg::cmt_cnt_t                     ret_cnt,
	output rob_pkg::ret_slot_t [`CMT_WIDTH-1:0]   ret_slots,
	output logic                                  flush
);
	import rob_pkg::*;

	rob_ndx_t                     head;
	rob_ndx_t                     tail;
	logic                         disp_we;
	logic                         ret_we;
	logic                         flush_now;
	cmt_cnt_t                     cmt_cnt;
	logic                         cmt_flush;
	rob_entry_t [`ROB_ENTRIES-1:0] entries;

	// The dispatched entry lands at the current tail
	assign disp_ndx = tail;

	rob_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.cmt_cnt    (cmt_cnt),
		.cmt_flush  (cmt_flush),
		.head       (head),
		.tail       (tail),
		.disp_we    (disp_we),
		.full       (full),
		.ret_we     (ret_we),
		.flush_now  (flush_now),
		.flush      (flush)
	);

	rob_entry_array u_array (
		.clk       (clk),
		.rst       (rst),
		.disp_we   (disp_we),
		.tail      (tail),
		.disp      (disp),
		.cpl_valid (cpl_valid),
		.cpl       (cpl),
		.head      (head),
		.ret_we    (ret_we),
		.cmt_cnt   (cmt_cnt),
		.flush_now (flush_now),
		.entries   (entries),
		.ret_valid (ret_valid),
		.ret_cnt   (ret_cnt),
		.ret_slots (ret_slots)
	);

	// Purely combinational, so it takes neither clock nor reset
	rob_commit_count u_cmt (
		.entries   (entries),
		.head      (head),
		.cmt_cnt   (cmt_cnt),
		.cmt_flush (cmt_flush)
	);

endmodule

// ==== tb_rob_top.sv ====
// ====================================================================
// Testbench for the reorder buffer retirement block
// Clock and reset, LCG driven dispatch and out of order completion,
// a queue model of the buffer that predicts every retire group,
// typed compare tasks and the end of run report
// ====================================================================

`include "rob_defines.svh"

module tb_rob_top;
	import rob_pkg::*;

	localparam int RUN_CYCLES    = 3000;
	localparam int DRAIN_TIMEOUT = 400;
	localparam int IDLE_CYCLES   = 64;

	logic                        clk;
	logic                        rst;
	logic                        disp_valid;
	disp_t                       disp;
	rob_ndx_t                    disp_ndx;
	logic                        full;
	logic                        cpl_valid;
	cpl_t                        cpl;
	logic                        ret_valid;
	cmt_cnt_t                    ret_cnt;
	ret_slot_t [`CMT_WIDTH-1:0]  ret_slots;
	logic                        flush;

	// The model queue holds the oldest entry first and m_head tracks its index
	rob_entry_t mq[$];
	rob_ndx_t   m_head;
	logic [`CNDX_W-1:0] m_cndx;

	// What the DUT must show during the cycle after the latest edge
	logic                       exp_ret_valid;
	cmt_cnt_t                   exp_cnt;
	logic                       exp_flush;
	ret_slot_t [`CMT_WIDTH-1:0] exp_slots;

	logic [31:0] seed = 32'h8a322daf;
	int n_retired;
	int n_flush;
	int n_dropped;

	rob_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.disp       (disp),
		.disp_ndx   (disp_ndx),
		.full       (full),
		.cpl_valid  (cpl_valid),
		.cpl        (cpl),
		.ret_valid  (ret_valid),
		.ret_cnt    (ret_cnt),
		.ret_slots  (ret_slots),
		.flush      (flush)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ================================================================
	// Random numbers and error handling
	// ================================================================

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Take the upper bits since the low bits of an LCG cycle with a short period
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:16]) % n;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cnt(input string name, input cmt_cnt_t got, input cmt_cnt_t exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_ndx(input string name, input rob_ndx_t got, input rob_ndx_t exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_ret(input int lane, input ret_slot_t got, input ret_slot_t exp);
		// An exception record is read back through the union first
		if (exp.excv && got.result.exc !== exp.result.exc)
			abort_run($sformatf("Error: ret_slots[%0d].result.exc got %h expected %h",
				lane, got.result.exc, exp.result.exc));
		if (got !== exp)
			abort_run($sformatf("Error: ret_slots[%0d] got %h expected %h", lane, got, exp));
	endtask

	// ================================================================
	// Reference model
	// ================================================================

	// The group is the leading run of done entries that share the head's
	// checkpoint index and it closes right after an oddball or excepting entry
	function automatic cmt_cnt_t group_size(output logic fl);
		cmt_cnt_t cnt;
		int       k;
		cnt = '0;
		fl  = 1'b0;
		for (k = 0; k < `CMT_WIDTH && k < mq.size(); k++) begin
			if (!mq[k].done || mq[k].cndx != mq[0].cndx)
				break;
			cnt = cmt_cnt_t'(k + 1);
			fl  = mq[k].excv;
			if (mq[k].oddball || mq[k].excv)
				break;
		end
		return cnt;
	endfunction

	// Applies the inputs the DUT sampled at this edge to the model
	task automatic model_edge();
		cmt_cnt_t   cnt;
		logic       fl;
		logic       accept;
		int         pos;
		int         k;
		rob_entry_t e;
		cnt           = group_size(fl);
		exp_ret_valid = (cnt != '0);
		exp_cnt       = cnt;
		exp_flush     = fl;
		for (k = 0; k < `CMT_WIDTH; k++) begin
			exp_slots[k] = '0;
			if (k < int'(cnt)) begin
				exp_slots[k].tag     = mq[k].tag;
				exp_slots[k].cndx    = mq[k].cndx;
				exp_slots[k].oddball = mq[k].oddball;
				exp_slots[k].excv    = mq[k].excv;
				exp_slots[k].result  = mq[k].result;
			end
		end
		accept = disp_valid && (mq.size() < `ROB_ENTRIES) && !fl;
		if (disp_valid && fl)
			n_dropped++;
		// Completion lands before the group leaves and never hits a retiring entry
		if (cpl_valid) begin
			pos      = int'(rob_ndx_t'(cpl.ndx - m_head));
			e        = mq[pos];
			e.done   = 1'b1;
			e.excv   = cpl.excv;
			e.result = cpl.result;
			mq[pos]  = e;
		end
		for (k = 0; k < int'(cnt); k++)
			void'(mq.pop_front());
		if (fl) begin
			mq.delete();
			n_flush++;
		end
		m_head    = m_head + rob_ndx_t'(cnt);
		n_retired = n_retired + int'(cnt);
		if (accept) begin
			e         = '0;
			e.valid   = 1'b1;
			e.tag     = disp.tag;
			e.cndx    = disp.cndx;
			e.oddball = disp.oddball;
			mq.push_back(e);
		end
	endtask

	// ================================================================
	// Stimulus and per cycle checks
	// ================================================================

	task automatic drive_stimulus(input bit allow_disp, input bit allow_cpl);
		logic [31:0] r;
		disp_t       d;
		cpl_t        c;
		int          undone[$];
		int          k;
		d = '0;
		c = '0;
		if (allow_disp && mq.size() < `ROB_ENTRIES && rand_below(8) < 5) begin
			// The checkpoint index moves on only now and then
			if (rand_below(16) == 0) begin
				r      = lcg_next();
				m_cndx = r[15:14];
			end
			r         = lcg_next();
			d.tag     = r[31:16];
			d.cndx    = m_cndx;
			d.oddball = (rand_below(8) == 0);
			disp_valid <= 1'b1;
		end else begin
			disp_valid <= 1'b0;
		end
		disp <= d;
		for (k = 0; k < mq.size(); k++) begin
			if (!mq[k].done)
				undone.push_back(k);
		end
		if (allow_cpl && undone.size() != 0 && rand_below(4) != 0) begin
			k     = undone[rand_below(undone.size())];
			c.ndx = m_head + rob_ndx_t'(k);
			r     = lcg_next();
			if (rand_below(16) == 0) begin
				c.excv             = 1'b1;
				c.result.exc.cause = r[7:0];
				c.result.exc.fault = r[31:8];
			end else begin
				c.result.data = r;
			end
			cpl_valid <= 1'b1;
		end else begin
			cpl_valid <= 1'b0;
		end
		cpl <= c;
	endtask

	task automatic check_outputs();
		int k;
		check_flag("ret_valid", ret_valid, exp_ret_valid);
		check_cnt("ret_cnt", ret_cnt, exp_cnt);
		for (k = 0; k < `CMT_WIDTH; k++)
			check_ret(k, ret_slots[k], exp_slots[k]);
		check_flag("flush", flush, exp_flush);
		check_flag("full", full, logic'(mq.size() == `ROB_ENTRIES));
		check_ndx("disp_ndx", disp_ndx, m_head + rob_ndx_t'(mq.size()));
	endtask

	// Drive at the rising edge and look at the outputs at the falling one
	task automatic run_cycle(input bit allow_disp, input bit allow_cpl);
		@(posedge clk);
		model_edge();
		drive_stimulus(allow_disp, allow_cpl);
		@(negedge clk);
		check_outputs();
	endtask

	task automatic drain_buffer(input string phase);
		int n;
		n = 0;
		while (mq.size() != 0) begin
			if (n == DRAIN_TIMEOUT)
				abort_run({phase, ": the buffer did not drain before the timeout"});
			run_cycle(1'b0, 1'b1);
			n++;
		end
	endtask

	// ================================================================
	// Test sequence
	// ================================================================

	initial begin
		int n;
		rst        = 1'b1;
		disp_valid = 1'b0;
		disp       = '0;
		cpl_valid  = 1'b0;
		cpl        = '0;
		m_head     = '0;
		m_cndx     = '0;
		exp_ret_valid = 1'b0;
		exp_cnt       = '0;
		exp_flush     = 1'b0;
		exp_slots     = '0;
		n_retired = 0;
		n_flush   = 0;
		n_dropped = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_outputs();

		for (n = 0; n < RUN_CYCLES; n++)
			run_cycle(1'b1, 1'b1);
		drain_buffer("Random phase drain");

		// Without completions nothing may leave the buffer while dispatch
		// fills it up to the top
		for (n = 0; n < IDLE_CYCLES; n++)
			run_cycle(1'b1, 1'b0);
		if (mq.size() != `ROB_ENTRIES)
			abort_run("The idle phase did not fill the buffer");
		drain_buffer("Final drain");

		if (n_flush == 0) begin
			abort_run("No exception flush happened during the run");
		end else begin
			$display("Retired %0d entries, %0d flushes, %0d dispatches dropped on a flush",
				n_retired, n_flush, n_dropped);
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule
